// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_chdr_ingress
FILELIST  = files.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== files.f ====
+incdir+source
source/chdr_xb_pkg.sv
source/chdr_ingress_decode.sv
source/chdr_packet_gate.sv
source/chdr_route_table.sv
source/chdr_dest_join.sv
source/chdr_ingress_top.sv
testbench/tb_chdr_ingress.sv

// ==== source/chdr_dest_join.sv ====
// Destination join, queues per-packet destinations and pairs the head
// entry with the gated packet words on the output stream
`timescale 1ns/100ps
`include "chdr_xb_consts.svh"

module chdr_dest_join (
  input  logic                     clk,
  input  logic                     reset,
  input  chdr_xb_pkg::dest_entry_t i_direct_entry,
  input  logic                     i_direct_tvalid,
  output logic                     o_direct_tready,
  input  chdr_xb_pkg::dest_entry_t i_result_entry,
  input  logic                     i_result_tvalid,
  output logic                     o_result_tready,
  input  logic [`CHDR_W-1:0]       i_pkt_tdata,
  input  logic                     i_pkt_tlast,
  input  logic                     i_pkt_tvalid,
  output logic                     o_pkt_tready,
  output logic [`CHDR_W-1:0]       o_tdata,
  output logic [`DEST_W-1:0]       o_tdest,
  output logic                     o_tkeep,
  output logic                     o_tlast,
  output logic                     o_tvalid,
  input  logic                     i_tready
);

  chdr_xb_pkg::dest_entry_t q [2];
  chdr_xb_pkg::dest_entry_t push_entry;
  logic [1:0]               count;
  logic [1:0]               push_pos;
  logic                     head_valid;
  logic                     room;
  logic                     push;
  logic                     pop;

  assign head_valid = (count != 2'd0);
  assign room       = (count != 2'd2);

  // Lookup results win over direct entries when both are offered
  assign o_result_tready = room;
  assign o_direct_tready = room && !i_result_tvalid;
  assign push            = room && (i_result_tvalid || i_direct_tvalid);
  assign push_entry      = i_result_tvalid ? i_result_entry : i_direct_entry;

  // Packet words only move once their destination is known
  assign o_tdata      = i_pkt_tdata;
  assign o_tlast      = i_pkt_tlast;
  assign o_tdest      = q[0].dest;
  assign o_tkeep      = q[0].keep;
  assign o_tvalid     = i_pkt_tvalid && head_valid;
  assign o_pkt_tready = i_tready && head_valid;

  // The head entry is released with the last word of its packet
  assign pop      = o_tvalid && i_tready && i_pkt_tlast;
  assign push_pos = count - {1'b0, pop};

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 2'd0;
    end else begin
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  // Shift on pop, then write the new entry behind whatever remains
  always_ff @(posedge clk) begin
    if (pop) begin
      q[0] <= q[1];
    end
    if (push) begin
      q[push_pos[0]] <= push_entry;
    end
  end

endmodule

// ==== source/chdr_ingress_decode.sv ====
// Header inspector for the ingress port, forwards words to the packet gate
// and issues one lookup request or one direct destination per packet
`timescale 1ns/100ps
`include "chdr_xb_consts.svh"

module chdr_ingress_decode (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`CHDR_W-1:0]       i_chdr_tdata,
  input  logic [`DEST_W-1:0]       i_chdr_tdest,
  input  logic [1:0]               i_chdr_tid,
  input  logic                     i_chdr_tlast,
  input  logic                     i_chdr_tvalid,
  output logic                     o_chdr_tready,
  output logic [`CHDR_W-1:0]       o_gate_tdata,
  output logic                     o_gate_tlast,
  output logic                     o_gate_tvalid,
  input  logic                     i_gate_tready,
  output logic [`EPID_W-1:0]       o_find_epid,
  output logic                     o_find_tvalid,
  input  logic                     i_find_tready,
  output chdr_xb_pkg::dest_entry_t o_dest_entry,
  output logic                     o_dest_tvalid,
  input  logic                     i_dest_tready
);

  chdr_xb_pkg::chdr_route_e route;
  logic                     is_hdr;
  logic                     find_room;
  logic                     dest_room;
  logic                     path_room;
  logic                     accept;
  logic                     hdr_stb;

  assign route = chdr_xb_pkg::chdr_route_e'(i_chdr_tid);

  // A one-entry buffer has room when empty or when it drains this cycle
  assign find_room = !o_find_tvalid || i_find_tready;
  assign dest_room = !o_dest_tvalid || i_dest_tready;

  // A header waits until both paths are clear, not only the chosen one
  // This stops a later direct entry from overtaking an earlier lookup
  assign path_room = !is_hdr || (find_room && dest_room);

  // Words pass straight into the gate
  assign o_gate_tdata  = i_chdr_tdata;
  assign o_gate_tlast  = i_chdr_tlast;
  assign o_gate_tvalid = i_chdr_tvalid && path_room;

  // Input ready follows input valid, as on the crossbar port it replaces
  assign o_chdr_tready = i_chdr_tvalid && i_gate_tready && path_room;
  assign accept        = i_chdr_tvalid && o_chdr_tready;
  assign hdr_stb       = accept && is_hdr;

  // The word after a last word is always a header
  always_ff @(posedge clk) begin
    if (reset) begin
      is_hdr <= 1'b1;
    end else if (accept) begin
      is_hdr <= i_chdr_tlast;
    end
  end

  // --------------------------------------------------------------------------
  // Lookup and direct-destination buffers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      o_find_tvalid <= 1'b0;
      o_dest_tvalid <= 1'b0;
    end else begin
      if (hdr_stb && route == chdr_xb_pkg::ROUTE_EPID) begin
        o_find_tvalid <= 1'b1;
      end else if (i_find_tready) begin
        o_find_tvalid <= 1'b0;
      end
      if (hdr_stb && route != chdr_xb_pkg::ROUTE_EPID) begin
        o_dest_tvalid <= 1'b1;
      end else if (i_dest_tready) begin
        o_dest_tvalid <= 1'b0;
      end
    end
  end

  // Payloads load only on a header, so they stay stable while waiting
  always_ff @(posedge clk) begin
    if (hdr_stb && route == chdr_xb_pkg::ROUTE_EPID) begin
      o_find_epid <= i_chdr_tdata[`EPID_W-1:0];
    end
    if (hdr_stb && route != chdr_xb_pkg::ROUTE_EPID) begin
      o_dest_entry.keep <= 1'b1;
      // Return-to-source goes back to this port, other codes use TDEST
      if (route == chdr_xb_pkg::RETURN_TO_SRC) begin
        o_dest_entry.dest <= `DEST_W'(`NODE_ID);
      end else begin
        o_dest_entry.dest <= i_chdr_tdest;
      end
    end
  end

endmodule

// ==== source/chdr_ingress_top.sv ====
// Ingress side of one crossbar port, gates each packet and tags it with
// its output port and a keep flag before it enters the crossbar
`timescale 1ns/100ps
`include "chdr_xb_consts.svh"

module chdr_ingress_top (
  input  logic               clk,
  input  logic               reset,
  input  logic [`CHDR_W-1:0] i_chdr_tdata,
  input  logic [`DEST_W-1:0] i_chdr_tdest,
  input  logic [1:0]         i_chdr_tid,
  input  logic               i_chdr_tlast,
  input  logic               i_chdr_tvalid,
  output logic               o_chdr_tready,
  output logic [`CHDR_W-1:0] o_chdr_tdata,
  output logic [`DEST_W-1:0] o_chdr_tdest,
  output logic               o_chdr_tkeep,
  output logic               o_chdr_tlast,
  output logic               o_chdr_tvalid,
  input  logic               i_chdr_tready,
  input  logic               i_cfg_wr,
  input  logic [`EPID_W-1:0] i_cfg_epid,
  input  logic [`DEST_W-1:0] i_cfg_port
);

  // --------------------------------------------------------------------------
  // Internal streams
  // --------------------------------------------------------------------------

  // Decode to gate
  logic [`CHDR_W-1:0]       gate_i_tdata;
  logic                     gate_i_tlast;
  logic                     gate_i_tvalid;
  logic                     gate_i_tready;
  // Gate to join
  logic [`CHDR_W-1:0]       gate_o_tdata;
  logic                     gate_o_tlast;
  logic                     gate_o_tvalid;
  logic                     gate_o_tready;
  // Decode to table, table to join
  logic [`EPID_W-1:0]       find_epid;
  logic                     find_tvalid;
  logic                     find_tready;
  chdr_xb_pkg::dest_entry_t result_entry;
  logic                     result_tvalid;
  logic                     result_tready;
  // Decode to join
  chdr_xb_pkg::dest_entry_t direct_entry;
  logic                     direct_tvalid;
  logic                     direct_tready;

  chdr_ingress_decode chdr_ingress_decode_inst (
    .clk           (clk),
    .reset         (reset),
    .i_chdr_tdata  (i_chdr_tdata),
    .i_chdr_tdest  (i_chdr_tdest),
    .i_chdr_tid    (i_chdr_tid),
    .i_chdr_tlast  (i_chdr_tlast),
    .i_chdr_tvalid (i_chdr_tvalid),
    .o_chdr_tready (o_chdr_tready),
    .o_gate_tdata  (gate_i_tdata),
    .o_gate_tlast  (gate_i_tlast),
    .o_gate_tvalid (gate_i_tvalid),
    .i_gate_tready (gate_i_tready),
    .o_find_epid   (find_epid),
    .o_find_tvalid (find_tvalid),
    .i_find_tready (find_tready),
    .o_dest_entry  (direct_entry),
    .o_dest_tvalid (direct_tvalid),
    .i_dest_tready (direct_tready)
  );

  chdr_packet_gate chdr_packet_gate_inst (
    .clk      (clk),
    .reset    (reset),
    .i_tdata  (gate_i_tdata),
    .i_tlast  (gate_i_tlast),
    .i_tvalid (gate_i_tvalid),
    .o_tready (gate_i_tready),
    .o_tdata  (gate_o_tdata),
    .o_tlast  (gate_o_tlast),
    .o_tvalid (gate_o_tvalid),
    .i_tready (gate_o_tready)
  );

  chdr_route_table chdr_route_table_inst (
    .clk             (clk),
    .reset           (reset),
    .i_cfg_wr        (i_cfg_wr),
    .i_cfg_epid      (i_cfg_epid),
    .i_cfg_port      (i_cfg_port),
    .i_find_epid     (find_epid),
    .i_find_tvalid   (find_tvalid),
    .o_find_tready   (find_tready),
    .o_result_entry  (result_entry),
    .o_result_tvalid (result_tvalid),
    .i_result_tready (result_tready)
  );

  chdr_dest_join chdr_dest_join_inst (
    .clk             (clk),
    .reset           (reset),
    .i_direct_entry  (direct_entry),
    .i_direct_tvalid (direct_tvalid),
    .o_direct_tready (direct_tready),
    .i_result_entry  (result_entry),
    .i_result_tvalid (result_tvalid),
    .o_result_tready (result_tready),
    .i_pkt_tdata     (gate_o_tdata),
    .i_pkt_tlast     (gate_o_tlast),
    .i_pkt_tvalid    (gate_o_tvalid),
    .o_pkt_tready    (gate_o_tready),
    .o_tdata         (o_chdr_tdata),
    .o_tdest         (o_chdr_tdest),
    .o_tkeep         (o_chdr_tkeep),
    .o_tlast         (o_chdr_tlast),
    .o_tvalid        (o_chdr_tvalid),
    .i_tready        (i_chdr_tready)
  );

endmodule

// ==== source/chdr_packet_gate.sv ====
// Whole-packet buffer, a packet becomes readable only once its last word
// is stored, so it always leaves as one unbroken burst
`timescale 1ns/100ps
`include "chdr_xb_consts.svh"

module chdr_packet_gate (
  input  logic               clk,
  input  logic               reset,
  input  logic [`CHDR_W-1:0] i_tdata,
  input  logic               i_tlast,
  input  logic               i_tvalid,
  output logic               o_tready,
  output logic [`CHDR_W-1:0] o_tdata,
  output logic               o_tlast,
  output logic               o_tvalid,
  input  logic               i_tready
);

  localparam int DEPTH = 2 ** `MTU_LOG2;

  // Each entry is the last flag above the data word
  logic [`CHDR_W:0]   mem [DEPTH];
  logic [`MTU_LOG2:0] wr_ptr;
  logic [`MTU_LOG2:0] rd_ptr;
  logic [`MTU_LOG2:0] cmt_ptr;
  logic [`MTU_LOG2:0] used;
  logic               wr_en;
  logic               rd_en;

  // Pointers carry one extra bit, so a full memory reads as used == DEPTH
  assign used     = wr_ptr - rd_ptr;
  assign o_tready = !used[`MTU_LOG2];
  assign wr_en    = i_tvalid && o_tready;

  // The read side only sees words below the committed pointer
  assign o_tvalid = (rd_ptr != cmt_ptr);
  assign rd_en    = o_tvalid && i_tready;

  // Asynchronous read lets a committed word show on the very next cycle
  assign {o_tlast, o_tdata} = mem[rd_ptr[`MTU_LOG2-1:0]];

  // --------------------------------------------------------------------------
  // Pointer control
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      cmt_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        // Commit the packet along with its last word
        if (i_tlast) begin
          cmt_ptr <= wr_ptr + 1'b1;
        end
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[`MTU_LOG2-1:0]] <= {i_tlast, i_tdata};
    end
  end

endmodule

// ==== source/chdr_route_table.sv ====
// EPID routing table, written through a plain strobe port and searched
// one request at a time on the find stream
`timescale 1ns/100ps
`include "chdr_xb_consts.svh"

module chdr_route_table (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_cfg_wr,
  input  logic [`EPID_W-1:0]       i_cfg_epid,
  input  logic [`DEST_W-1:0]       i_cfg_port,
  input  logic [`EPID_W-1:0]       i_find_epid,
  input  logic                     i_find_tvalid,
  output logic                     o_find_tready,
  output chdr_xb_pkg::dest_entry_t o_result_entry,
  output logic                     o_result_tvalid,
  input  logic                     i_result_tready
);

  localparam int IDX_W = $clog2(`RT_ENTRIES);

  logic               ent_valid [`RT_ENTRIES];
  logic [`EPID_W-1:0] ent_epid  [`RT_ENTRIES];
  logic [`DEST_W-1:0] ent_port  [`RT_ENTRIES];
  logic [IDX_W:0]     fill;
  logic               wr_hit;
  logic [IDX_W-1:0]   wr_idx;
  logic               wr_en;
  logic               find_hit;
  logic [`DEST_W-1:0] find_port;
  logic               find_stb;

  // Compare both the write EPID and the find EPID against every entry
  always_comb begin
    wr_hit    = 1'b0;
    wr_idx    = fill[IDX_W-1:0];
    find_hit  = 1'b0;
    find_port = '0;
    for (int i = 0; i < `RT_ENTRIES; i++) begin
      if (ent_valid[i] && ent_epid[i] == i_cfg_epid) begin
        wr_hit = 1'b1;
        wr_idx = IDX_W'(i);
      end
      if (ent_valid[i] && ent_epid[i] == i_find_epid) begin
        find_hit  = 1'b1;
        find_port = ent_port[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Table update
  // --------------------------------------------------------------------------

  // A known EPID is rewritten in place, a new one takes the next free slot
  // New EPIDs are ignored once every slot is used
  assign wr_en = i_cfg_wr && (wr_hit || !fill[IDX_W]);

  always_ff @(posedge clk) begin
    if (reset) begin
      fill <= '0;
      for (int i = 0; i < `RT_ENTRIES; i++) begin
        ent_valid[i] <= 1'b0;
      end
    end else if (wr_en) begin
      ent_valid[wr_idx] <= 1'b1;
      if (!wr_hit) begin
        fill <= fill + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      ent_epid[wr_idx] <= i_cfg_epid;
      ent_port[wr_idx] <= i_cfg_port;
    end
  end

  // --------------------------------------------------------------------------
  // Lookup
  // --------------------------------------------------------------------------

  // One result at a time, held until the join takes it
  assign o_find_tready = !o_result_tvalid;
  assign find_stb      = i_find_tvalid && o_find_tready;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_result_tvalid <= 1'b0;
    end else if (find_stb) begin
      o_result_tvalid <= 1'b1;
    end else if (i_result_tready) begin
      o_result_tvalid <= 1'b0;
    end
  end

  // A miss gives keep low and port zero
  always_ff @(posedge clk) begin
    if (find_stb) begin
      o_result_entry.keep <= find_hit;
      o_result_entry.dest <= find_port;
    end
  end

endmodule

// ==== source/chdr_xb_consts.svh ====
// Shared sizing constants for the CHDR crossbar ingress port
// Include this header wherever a width, depth or node number is needed
`ifndef CHDR_XB_CONSTS_SVH
`define CHDR_XB_CONSTS_SVH

// Width of one CHDR data word
`define CHDR_W 64

// Width of a crossbar output port number (TDEST)
`define DEST_W 4

// The packet gate holds 2**MTU_LOG2 words, which is also the longest packet
`define MTU_LOG2 5

// Port number of this ingress port, used for return-to-source packets
`define NODE_ID 3

// Destination endpoint ID width, taken from the low bits of the header
`define EPID_W 16

// Number of entries in the EPID routing table
`define RT_ENTRIES 8

`endif

// ==== source/chdr_xb_pkg.sv ====
// Types shared by the ingress port blocks
// Refer to them by scoped name, for example chdr_xb_pkg::dest_entry_t
`include "chdr_xb_consts.svh"

package chdr_xb_pkg;

  // --------------------------------------------------------------------------
  // Route mode carried on TID with each packet
  // --------------------------------------------------------------------------

  // Code 3 is unused and decode handles it like ROUTE_TDEST
  typedef enum logic [1:0] {
    ROUTE_EPID    = 2'd0,
    ROUTE_TDEST   = 2'd1,
    RETURN_TO_SRC = 2'd2
  } chdr_route_e;

  // --------------------------------------------------------------------------
  // Destination queue entry
  // --------------------------------------------------------------------------

  // Keep low tells the crossbar to drop the packet (lookup miss)
  typedef struct packed {
    logic               keep;
    logic [`DEST_W-1:0] dest;
  } dest_entry_t;

endpackage

// ==== testbench/tb_chdr_ingress.sv ====
// Self-checking testbench for the CHDR ingress port, driving LFSR packets and
// back-pressure and scoring each output word against a model of the routing rules
`timescale 1ns/100ps
`include "chdr_xb_consts.svh"

module tb_chdr_ingress;

  localparam int          NUM_PKTS = 40;
  localparam int          MAX_LEN  = 2 ** `MTU_LOG2;
  localparam int          TIMEOUT  = NUM_PKTS * MAX_LEN * 4 + 500;
  localparam logic [31:0] SEED     = 32'h5f0653ce;

  logic               clk;
  logic               reset;
  logic [`CHDR_W-1:0] i_chdr_tdata;
  logic [`DEST_W-1:0] i_chdr_tdest;
  logic [1:0]         i_chdr_tid;
  logic               i_chdr_tlast;
  logic               i_chdr_tvalid;
  logic               o_chdr_tready;
  logic [`CHDR_W-1:0] o_chdr_tdata;
  logic [`DEST_W-1:0] o_chdr_tdest;
  logic               o_chdr_tkeep;
  logic               o_chdr_tlast;
  logic               o_chdr_tvalid;
  logic               i_chdr_tready;
  logic               i_cfg_wr;
  logic [`EPID_W-1:0] i_cfg_epid;
  logic [`DEST_W-1:0] i_cfg_port;

  int                 mismatches;
  int                 proto_errors;
  int                 other_errors;
  int                 cycles;
  int                 in_done;
  logic [31:0]        in_lfsr;

  // Copy of what the routing table should hold
  logic [`EPID_W-1:0] tb_epid [`RT_ENTRIES];
  logic [`DEST_W-1:0] tb_port [`RT_ENTRIES];

  // Scoreboard, one entry per expected output word
  logic [`CHDR_W-1:0] exp_data [$];
  logic               exp_last [$];
  logic [`DEST_W-1:0] exp_dest [$];
  logic               exp_keep [$];
  string              exp_test [$];

  chdr_ingress_top chdr_ingress_top_inst (
    .clk           (clk),
    .reset         (reset),
    .i_chdr_tdata  (i_chdr_tdata),
    .i_chdr_tdest  (i_chdr_tdest),
    .i_chdr_tid    (i_chdr_tid),
    .i_chdr_tlast  (i_chdr_tlast),
    .i_chdr_tvalid (i_chdr_tvalid),
    .o_chdr_tready (o_chdr_tready),
    .o_chdr_tdata  (o_chdr_tdata),
    .o_chdr_tdest  (o_chdr_tdest),
    .o_chdr_tkeep  (o_chdr_tkeep),
    .o_chdr_tlast  (o_chdr_tlast),
    .o_chdr_tvalid (o_chdr_tvalid),
    .i_chdr_tready (i_chdr_tready),
    .i_cfg_wr      (i_cfg_wr),
    .i_cfg_epid    (i_cfg_epid),
    .i_cfg_port    (i_cfg_port)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Random source and helpers
  // --------------------------------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
    $display("Mismatch in %s, %s: expected %0h, actual %0h", test, field, expected, actual);
    mismatches++;
  endtask

  task automatic write_table(input logic [`EPID_W-1:0] epid, input logic [`DEST_W-1:0] port);
    i_cfg_wr   = 1'b1;
    i_cfg_epid = epid;
    i_cfg_port = port;
    @(negedge clk);
    i_cfg_wr   = 1'b0;
  endtask

  // Route mode 0 looks up the EPID, 2 returns to this node, 1 and 3 use TDEST
  task automatic expected_route(input logic [1:0] tid, input logic [`DEST_W-1:0] tdest,
                                input logic [`EPID_W-1:0] epid,
                                output logic [`DEST_W-1:0] dest, output logic keep,
                                output string test);
    dest = '0;
    keep = 1'b0;
    test = "route_epid_miss";
    case (tid)
      2'd0: begin
        for (int i = 0; i < `RT_ENTRIES; i++) begin
          if (tb_epid[i] == epid) begin
            dest = tb_port[i];
            keep = 1'b1;
            test = "route_epid_hit";
          end
        end
      end
      2'd2: begin
        dest = `DEST_W'(`NODE_ID);
        keep = 1'b1;
        test = "return_to_src";
      end
      default: begin
        dest = tdest;
        keep = 1'b1;
        test = "route_tdest";
      end
    endcase
  endtask

  // Valid is already high, hold the word until a rising edge sees ready
  task automatic wait_accept();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = o_chdr_tready;
      @(negedge clk);
    end
  endtask

  task automatic send_packet(input int pkt_idx);
    logic [31:0]        r;
    int                 len;
    logic [1:0]         tid;
    logic [`DEST_W-1:0] tdest;
    logic [`EPID_W-1:0] epid;
    logic [`CHDR_W-1:0] word;
    logic [`DEST_W-1:0] dest;
    logic               keep;
    string              test;
    draw(in_lfsr, 5, r);
    len = int'(r[4:0]) + 1;
    // The first packet is full length, so the gate has to hold it back for many cycles
    if (pkt_idx == 0) begin
      len = MAX_LEN;
    end
    draw(in_lfsr, 2, r);
    tid = r[1:0];
    draw(in_lfsr, `DEST_W, r);
    tdest = r[`DEST_W-1:0];
    // Half the EPIDs are in the table, the rest were never written
    draw(in_lfsr, 4, r);
    epid = r[3] ? tb_epid[r[2:0]] : (16'h7f00 | 16'(r[2:0]));
    // The last packet looks up the rewritten entry
    if (pkt_idx == NUM_PKTS - 1) begin
      tid  = 2'd0;
      epid = tb_epid[5];
    end
    expected_route(tid, tdest, epid, dest, keep, test);
    for (int i = 0; i < len; i++) begin
      draw(in_lfsr, 2, r);
      if (r[1:0] == 2'b00) begin
        i_chdr_tvalid = 1'b0;
        @(negedge clk);
      end
      draw(in_lfsr, 32, r);
      word[63:32] = r;
      draw(in_lfsr, 32, r);
      word[31:0] = r;
      if (i == 0) begin
        word[`EPID_W-1:0] = epid;
      end
      i_chdr_tdata  = word;
      i_chdr_tlast  = (i == len - 1);
      i_chdr_tdest  = tdest;
      i_chdr_tid    = tid;
      i_chdr_tvalid = 1'b1;
      exp_data.push_back(word);
      exp_last.push_back(i == len - 1);
      exp_dest.push_back(dest);
      exp_keep.push_back(keep);
      exp_test.push_back(test);
      wait_accept();
    end
    i_chdr_tvalid = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    reset         = 1'b1;
    i_chdr_tdata  = '0;
    i_chdr_tdest  = '0;
    i_chdr_tid    = '0;
    i_chdr_tlast  = 1'b0;
    i_chdr_tvalid = 1'b0;
    i_cfg_wr      = 1'b0;
    i_cfg_epid    = '0;
    i_cfg_port    = '0;
    in_lfsr       = SEED;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    // Fill every table slot with a distinct EPID and a random port
    for (int i = 0; i < `RT_ENTRIES; i++) begin
      draw(in_lfsr, `DEST_W, r);
      tb_epid[i] = 16'h0100 + 16'(i * 5);
      tb_port[i] = r[`DEST_W-1:0];
      write_table(tb_epid[i], tb_port[i]);
    end
    // Rewrite one known EPID, later lookups must return the newer port
    tb_port[5] = tb_port[5] + `DEST_W'(1);
    write_table(tb_epid[5], tb_port[5]);
    for (int p = 0; p < NUM_PKTS; p++) begin
      send_packet(p);
    end
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Summary: %0d mismatches, %0d protocol errors, %0d other errors",
             mismatches, proto_errors, other_errors);
    if (mismatches + proto_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Output ready, mostly high with an occasional long stall that fills the gate
  initial begin
    logic [31:0] ready_lfsr;
    logic [31:0] r;
    int          stall;
    i_chdr_tready = 1'b0;
    stall         = 0;
    ready_lfsr    = SEED;
    // Offset so this stream does not repeat the input stream bit for bit
    repeat (64) ready_lfsr = lfsr_next(ready_lfsr);
    forever begin
      @(negedge clk);
      if (stall > 0) begin
        stall--;
        i_chdr_tready = 1'b0;
      end else begin
        draw(ready_lfsr, 5, r);
        if (r[4:0] == 5'd0) begin
          stall = 40;
        end
        i_chdr_tready = !reset && (r[1:0] != 2'b00);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Monitors and checks
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      in_done <= 0;
    end else if (i_chdr_tvalid && o_chdr_tready && i_chdr_tlast) begin
      in_done <= in_done + 1;
    end
  end

  always @(posedge clk) begin
    if (!reset && o_chdr_tvalid && i_chdr_tready) begin
      if (exp_data.size() == 0) begin
        $display("An output word arrived when no word was expected");
        other_errors++;
      end else begin
        assert (o_chdr_tdata == exp_data[0])
          else report_mismatch(exp_test[0], "tdata", exp_data[0], o_chdr_tdata);
        assert (o_chdr_tlast == exp_last[0])
          else report_mismatch(exp_test[0], "tlast", 64'(exp_last[0]), 64'(o_chdr_tlast));
        assert (o_chdr_tdest == exp_dest[0])
          else report_mismatch(exp_test[0], "tdest", 64'(exp_dest[0]), 64'(o_chdr_tdest));
        assert (o_chdr_tkeep == exp_keep[0])
          else report_mismatch(exp_test[0], "tkeep", 64'(exp_keep[0]), 64'(o_chdr_tkeep));
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
        void'(exp_dest.pop_front());
        void'(exp_keep.pop_front());
        void'(exp_test.pop_front());
      end
    end
  end

  reset_clears_valid: assert property (@(posedge clk) reset |=> !o_chdr_tvalid)
    else begin
      $display("Output valid was high right after reset");
      proto_errors++;
    end

  // Nothing may leave before the first packet has been completely written
  first_packet_gated: assert property (@(posedge clk) disable iff (reset)
      (in_done == 0) |-> !o_chdr_tvalid)
    else begin
      $display("Output valid rose before the first packet was fully written");
      proto_errors++;
    end

  // Once a packet starts, valid stays up until its last word is taken
  packet_contiguous: assert property (@(posedge clk) disable iff (reset)
      (o_chdr_tvalid && !(i_chdr_tready && o_chdr_tlast)) |=> o_chdr_tvalid)
    else begin
      $display("Output valid fell in the middle of a packet");
      proto_errors++;
    end

  dest_fixed_in_packet: assert property (@(posedge clk) disable iff (reset)
      (o_chdr_tvalid && !o_chdr_tlast) |=> ($stable(o_chdr_tdest) && $stable(o_chdr_tkeep)))
    else begin
      $display("Output TDEST or keep changed inside a packet");
      proto_errors++;
    end

  output_held_stalled: assert property (@(posedge clk) disable iff (reset)
      (o_chdr_tvalid && !i_chdr_tready) |=> ($stable(o_chdr_tdata) && $stable(o_chdr_tlast)
                                             && $stable(o_chdr_tdest) && $stable(o_chdr_tkeep)))
    else begin
      $display("Output word changed while valid was high and ready was low");
      proto_errors++;
    end

  // Hard stop in case the DUT stops moving words
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles with %0d words still expected",
               cycles, exp_data.size());
      $display("Errors found");
      $finish;
    end
  end

endmodule
